// File: rtl/csi2_pkg.sv
`default_nettype none

package csi2_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [3:0]  vc_t;
   typedef logic [5:0]  dt_t;
   typedef logic [15:0] field_t;
   typedef logic [15:0] crc_t;

   // short packet data types
   localparam dt_t DT_FS = 6'h00;
   localparam dt_t DT_FE = 6'h01;
   localparam dt_t DT_LS = 6'h02;
   localparam dt_t DT_LE = 6'h03;

   localparam dt_t  DT_LONG_DEFAULT = 6'h2B;
   localparam crc_t CRC_SEED        = 16'hFFFF;

   typedef enum logic [2:0] {IDLE, FS, LS, LONG, LE, FE} seq_state_t;

   //////////////////////////////
   // header ECC, d = {vc[3:2], field, vc[1:0], dt}
   //////////////////////////////
   function automatic byte_t ecc_calc(input logic [25:0] d);
      byte_t e;
      e[0] = ^{d[0], d[1], d[2], d[4], d[5], d[7], d[10], d[11], d[13], d[16],
               d[20], d[21], d[22], d[23], d[24]};
      e[1] = ^{d[0], d[1], d[3], d[4], d[6], d[8], d[10], d[12], d[14], d[17],
               d[20], d[21], d[22], d[23], d[25]};
      e[2] = ^{d[0], d[2], d[3], d[5], d[6], d[9], d[11], d[12], d[15], d[18],
               d[20], d[21], d[22], d[24], d[25]};
      e[3] = ^{d[1], d[2], d[3], d[7], d[8], d[9], d[13], d[14], d[15], d[19],
               d[20], d[21], d[23], d[24], d[25]};
      e[4] = ^{d[4], d[5], d[6], d[7], d[8], d[9], d[16], d[17], d[18], d[19],
               d[20], d[22], d[23], d[24], d[25]};
      e[5] = ^{d[10], d[11], d[12], d[13], d[14], d[15], d[16], d[17], d[18], d[19],
               d[21], d[22], d[23], d[24], d[25]};
      // top two bits carry the extended vc
      e[6] = d[24];
      e[7] = d[25];
      return e;
   endfunction

   // one byte of CRC-16, lsb first, reflected poly 0x8408
   function automatic crc_t crc16_step(input crc_t crc, input byte_t b);
      crc_t c;
      logic fb;
      c = crc;
      for (int n = 0; n < 8; n++) begin
         fb = b[n] ^ c[0];
         c  = c >> 1;
         if (fb) begin
            c = c ^ 16'h8408;
         end
      end
      return c;
   endfunction

endpackage

`default_nettype wire

// File: rtl/csi2_frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_frame_sequencer #(
   parameter int LINES    = 4,
   parameter int FNUM_MAX = 3
) (
   input  wire logic             dphy_active,
   input  wire logic             rst_n_i,
   input  wire logic             start_i,
   input  wire logic             line_sync_en_i,
   output logic                  short_req_o,
   output csi2_pkg::dt_t         short_dt_o,
   output csi2_pkg::field_t      short_field_o,
   input  wire logic             short_done_i,
   output logic                  long_req_o,
   output csi2_pkg::field_t      line_o,
   input  wire logic             long_done_i,
   output logic                  busy_o
);
   import csi2_pkg::*;

   seq_state_t state_q;
   field_t     fnum_q;
   field_t     line_q;
   logic       sync_q;
   logic       tail_q;
   logic       last_line;

   assign last_line = (line_q == field_t'(LINES));

   //////////////////////////////
   // packet order
   //////////////////////////////
   always_ff @(posedge dphy_active) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         fnum_q  <= 16'd1;
         line_q  <= 16'd1;
         sync_q  <= 1'b0;
         tail_q  <= 1'b0;
      end else begin
         tail_q <= 1'b0;
         case (state_q)
            IDLE: begin
               if (start_i) begin
                  state_q <= FS;
                  line_q  <= 16'd1;
                  // line sync mode fixed for the whole frame
                  sync_q  <= line_sync_en_i;
               end
            end
            FS: begin
               if (short_done_i) begin
                  state_q <= sync_q ? LS : LONG;
               end
            end
            LS: begin
               if (short_done_i) begin
                  state_q <= LONG;
               end
            end
            LONG: begin
               if (long_done_i) begin
                  if (sync_q) begin
                     state_q <= LE;
                  end else if (last_line) begin
                     state_q <= FE;
                  end else begin
                     line_q <= line_q + 16'd1;
                  end
               end
            end
            LE: begin
               if (short_done_i) begin
                  state_q <= last_line ? FE : LS;
                  if (!last_line) begin
                     line_q <= line_q + 16'd1;
                  end
               end
            end
            FE: begin
               if (short_done_i) begin
                  state_q <= IDLE;
                  // covers the cycle the FE word leaves the arbiter
                  tail_q  <= 1'b1;
                  fnum_q  <= (fnum_q == field_t'(FNUM_MAX)) ? 16'd1 : fnum_q + 16'd1;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_comb begin
      short_req_o   = 1'b0;
      short_dt_o    = DT_FS;
      short_field_o = fnum_q;
      case (state_q)
         FS: short_req_o = 1'b1;
         FE: begin
            short_req_o = 1'b1;
            short_dt_o  = DT_FE;
         end
         LS: begin
            short_req_o   = 1'b1;
            short_dt_o    = DT_LS;
            short_field_o = line_q;
         end
         LE: begin
            short_req_o   = 1'b1;
            short_dt_o    = DT_LE;
            short_field_o = line_q;
         end
         default: short_req_o = 1'b0;
      endcase
   end

   assign long_req_o = (state_q == LONG);
   assign line_o     = line_q;
   assign busy_o     = (state_q != IDLE) || tail_q;

endmodule

`default_nettype wire

// File: rtl/csi2_short_pkt_gen.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_short_pkt_gen (
   input  wire logic             dphy_active,
   input  wire logic             rst_n_i,
   input  wire logic             req_i,
   input  wire csi2_pkg::dt_t    dt_i,
   input  wire csi2_pkg::field_t field_i,
   input  wire csi2_pkg::vc_t    vc_i,
   output logic                  valid_o,
   output csi2_pkg::byte_t       byte_o,
   output logic                  last_o,
   input  wire logic             ready_i,
   output logic                  done_o
);
   import csi2_pkg::*;

   byte_t      hdr_q [4];
   logic [1:0] idx_q;
   logic       active_q;
   logic       xfer;

   assign xfer = active_q && ready_i;

   always_ff @(posedge dphy_active) begin
      if (!rst_n_i) begin
         active_q <= 1'b0;
         idx_q    <= 2'd0;
      end else if (!active_q) begin
         if (req_i) begin
            active_q <= 1'b1;
            idx_q    <= 2'd0;
         end
      end else if (xfer) begin
         idx_q <= idx_q + 2'd1;
         if (last_o) begin
            active_q <= 1'b0;
         end
      end
   end

   // capture header on request
   always_ff @(posedge dphy_active) begin
      if (!active_q && req_i) begin
         hdr_q[0] <= {vc_i[1:0], dt_i};
         hdr_q[1] <= field_i[7:0];
         hdr_q[2] <= field_i[15:8];
         hdr_q[3] <= ecc_calc({vc_i[3:2], field_i, vc_i[1:0], dt_i});
      end
   end

   assign valid_o = active_q;
   assign byte_o  = hdr_q[idx_q];
   assign last_o  = (idx_q == 2'd3);
   assign done_o  = xfer && last_o;

endmodule

`default_nettype wire

// File: rtl/csi2_long_pkt_gen.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_long_pkt_gen #(
   parameter int WORD_COUNT = 30
) (
   input  wire logic             dphy_active,
   input  wire logic             rst_n_i,
   input  wire logic             req_i,
   input  wire csi2_pkg::field_t line_i,
   input  wire csi2_pkg::vc_t    vc_i,
   output logic                  valid_o,
   output csi2_pkg::byte_t       byte_o,
   output logic                  last_o,
   input  wire logic             ready_i,
   output logic                  done_o
);
   import csi2_pkg::*;

   // header, payload, two crc bytes
   localparam int     TOTAL = WORD_COUNT + 6;
   localparam int     IDX_W = $clog2(TOTAL);
   localparam field_t WC    = field_t'(WORD_COUNT);

   byte_t            hdr_q [4];
   field_t           line_q;
   crc_t             crc_q;
   logic [IDX_W-1:0] idx_q;
   logic [IDX_W-1:0] pay_k;
   logic             active_q;
   logic             xfer;
   logic             in_hdr;
   logic             in_pay;

   assign xfer   = active_q && ready_i;
   assign pay_k  = idx_q - IDX_W'(4);
   assign in_hdr = (idx_q < IDX_W'(4));
   assign in_pay = !in_hdr && (pay_k < IDX_W'(WORD_COUNT));
   assign last_o = (idx_q == IDX_W'(TOTAL - 1));

   always_ff @(posedge dphy_active) begin
      if (!rst_n_i) begin
         active_q <= 1'b0;
         idx_q    <= '0;
      end else if (!active_q) begin
         if (req_i) begin
            active_q <= 1'b1;
            idx_q    <= '0;
         end
      end else if (xfer) begin
         idx_q <= idx_q + IDX_W'(1);
         if (last_o) begin
            active_q <= 1'b0;
         end
      end
   end

   //////////////////////////////
   // header capture and crc
   //////////////////////////////
   always_ff @(posedge dphy_active) begin
      if (!active_q && req_i) begin
         hdr_q[0] <= {vc_i[1:0], DT_LONG_DEFAULT};
         hdr_q[1] <= WC[7:0];
         hdr_q[2] <= WC[15:8];
         hdr_q[3] <= ecc_calc({vc_i[3:2], WC, vc_i[1:0], DT_LONG_DEFAULT});
         line_q   <= line_i;
         crc_q    <= CRC_SEED;
      end else if (xfer && in_pay) begin
         crc_q <= crc16_step(crc_q, byte_o);
      end
   end

   always_comb begin
      if (in_hdr) begin
         byte_o = hdr_q[idx_q[1:0]];
      end else if (in_pay) begin
         // payload byte k of line n is k + n
         byte_o = byte_t'(pay_k) + line_q[7:0];
      end else if (last_o) begin
         byte_o = crc_q[15:8];
      end else begin
         byte_o = crc_q[7:0];
      end
   end

   assign valid_o = active_q;
   assign done_o  = xfer && last_o;

endmodule

`default_nettype wire

// File: rtl/csi2_lane_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_lane_arbiter #(
   parameter int LANES   = 4,
   parameter int CREDITS = 4
) (
   input  wire logic            dphy_active,
   input  wire logic            rst_n_i,
   input  wire logic            sp_valid_i,
   input  wire csi2_pkg::byte_t sp_byte_i,
   input  wire logic            sp_last_i,
   output logic                 sp_ready_o,
   input  wire logic            lp_valid_i,
   input  wire csi2_pkg::byte_t lp_byte_i,
   input  wire logic            lp_last_i,
   output logic                 lp_ready_o,
   input  wire logic            credit_i,
   output logic                 word_valid_o,
   output logic [LANES*8-1:0]   word_data_o,
   output logic [2:0]           word_nbytes_o
);
   import csi2_pkg::*;

   localparam int CW = $clog2(CREDITS + 1);

   byte_t         pack_q [LANES];
   logic [2:0]    cnt_q;
   logic [2:0]    base;
   logic          pend_q;
   logic          lock_q;
   logic          own_lp_q;
   logic [CW-1:0] credit_q;
   logic [CW-1:0] credit_nxt;
   logic          sel_lp;
   logic          sel_valid;
   byte_t         sel_byte;
   logic          sel_last;
   logic          emit;
   logic          ready;
   logic          acc;
   logic          word_done;

   // short packets win when both ask
   assign sel_lp    = lock_q ? own_lp_q : !sp_valid_i;
   assign sel_valid = sel_lp ? lp_valid_i : sp_valid_i;
   assign sel_byte  = sel_lp ? lp_byte_i : sp_byte_i;
   assign sel_last  = sel_lp ? lp_last_i : sp_last_i;

   assign emit = pend_q && (credit_q != '0);

   always_comb begin
      credit_nxt = credit_q;
      if (credit_i && !emit && (credit_q != CW'(CREDITS))) begin
         credit_nxt = credit_q + CW'(1);
      end else if (!credit_i && emit) begin
         credit_nxt = credit_q - CW'(1);
      end
   end

   // take a byte only when its word can leave on the next cycle
   assign ready      = (!pend_q || emit) && (credit_nxt != '0);
   assign acc        = ready && sel_valid;
   assign sp_ready_o = ready && !sel_lp;
   assign lp_ready_o = ready && sel_lp;

   assign base      = emit ? 3'd0 : cnt_q;
   assign word_done = ((base + 3'd1) == 3'(LANES)) || sel_last;

   //////////////////////////////
   // grant, packing, credits
   //////////////////////////////
   always_ff @(posedge dphy_active) begin
      if (!rst_n_i) begin
         cnt_q    <= 3'd0;
         pend_q   <= 1'b0;
         lock_q   <= 1'b0;
         own_lp_q <= 1'b0;
         credit_q <= CW'(CREDITS);
      end else begin
         credit_q <= credit_nxt;
         if (acc) begin
            cnt_q    <= base + 3'd1;
            pend_q   <= word_done;
            lock_q   <= !sel_last;
            own_lp_q <= sel_lp;
         end else if (emit) begin
            cnt_q  <= 3'd0;
            pend_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge dphy_active) begin
      for (int i = 0; i < LANES; i++) begin
         if (acc && (base == 3'(i))) begin
            pack_q[i] <= sel_byte;
         end
      end
   end

   // unused lanes of a partial word read as zero
   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         word_data_o[i*8 +: 8] = (3'(i) < cnt_q) ? pack_q[i] : 8'h00;
      end
   end

   assign word_valid_o  = emit;
   assign word_nbytes_o = cnt_q;

endmodule

`default_nettype wire

// File: rtl/csi2_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_tx_top #(
   parameter int LANES      = 4,
   parameter int WORD_COUNT = 30,
   parameter int LINES      = 4,
   parameter int FNUM_MAX   = 3,
   parameter int CREDITS    = 4
) (
   input  wire logic          dphy_active,
   input  wire logic          rst_n_i,
   input  wire logic          start_i,
   input  wire csi2_pkg::vc_t vc_i,
   input  wire logic          line_sync_en_i,
   input  wire logic          credit_i,
   output logic               word_valid_o,
   output logic [LANES*8-1:0] word_data_o,
   output logic [2:0]         word_nbytes_o,
   output logic               busy_o
);
   import csi2_pkg::*;

   logic   short_req;
   dt_t    short_dt;
   field_t short_field;
   logic   short_done;
   logic   long_req;
   field_t line;
   logic   long_done;

   // short and long byte streams into the arbiter
   logic   sp_valid;
   byte_t  sp_byte;
   logic   sp_last;
   logic   sp_ready;
   logic   lp_valid;
   byte_t  lp_byte;
   logic   lp_last;
   logic   lp_ready;

   csi2_frame_sequencer #(
      .LINES    (LINES),
      .FNUM_MAX (FNUM_MAX)
   ) seq_i (
      .dphy_active    (dphy_active),
      .rst_n_i        (rst_n_i),
      .start_i        (start_i),
      .line_sync_en_i (line_sync_en_i),
      .short_req_o    (short_req),
      .short_dt_o     (short_dt),
      .short_field_o  (short_field),
      .short_done_i   (short_done),
      .long_req_o     (long_req),
      .line_o         (line),
      .long_done_i    (long_done),
      .busy_o         (busy_o)
   );

   csi2_short_pkt_gen short_i (
      .dphy_active (dphy_active),
      .rst_n_i     (rst_n_i),
      .req_i       (short_req),
      .dt_i        (short_dt),
      .field_i     (short_field),
      .vc_i        (vc_i),
      .valid_o     (sp_valid),
      .byte_o      (sp_byte),
      .last_o      (sp_last),
      .ready_i     (sp_ready),
      .done_o      (short_done)
   );

   csi2_long_pkt_gen #(
      .WORD_COUNT (WORD_COUNT)
   ) long_i (
      .dphy_active (dphy_active),
      .rst_n_i     (rst_n_i),
      .req_i       (long_req),
      .line_i      (line),
      .vc_i        (vc_i),
      .valid_o     (lp_valid),
      .byte_o      (lp_byte),
      .last_o      (lp_last),
      .ready_i     (lp_ready),
      .done_o      (long_done)
   );

   csi2_lane_arbiter #(
      .LANES   (LANES),
      .CREDITS (CREDITS)
   ) arb_i (
      .dphy_active   (dphy_active),
      .rst_n_i       (rst_n_i),
      .sp_valid_i    (sp_valid),
      .sp_byte_i     (sp_byte),
      .sp_last_i     (sp_last),
      .sp_ready_o    (sp_ready),
      .lp_valid_i    (lp_valid),
      .lp_byte_i     (lp_byte),
      .lp_last_i     (lp_last),
      .lp_ready_o    (lp_ready),
      .credit_i      (credit_i),
      .word_valid_o  (word_valid_o),
      .word_data_o   (word_data_o),
      .word_nbytes_o (word_nbytes_o)
   );

endmodule

`default_nettype wire

// File: tb/csi2_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_tx_tb;
   import csi2_pkg::*;

   localparam int LANES      = 4;
   localparam int WORD_COUNT = 29;
   localparam int LINES      = 3;
   localparam int FNUM_MAX   = 3;
   localparam int CREDITS    = 3;
   localparam int PERIOD     = 40;
   localparam int SEED       = 80257;
   localparam int STALL_MIN  = 20;
   localparam int STALL_MAX  = 60;
   localparam int NUM_FRAMES = 6;
   // bytes of a frame with line sync on
   localparam int FRAME_BYTES = 4 * (2 + 2 * LINES) + LINES * (WORD_COUNT + 6);
   localparam int WATCHDOG_NS = FRAME_BYTES * (STALL_MAX + 4) * NUM_FRAMES * 2 * PERIOD;

   // syndrome column of each ECC input bit
   localparam logic [5:0] ECC_COL [26] = '{
      6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19, 6'h1A, 6'h1C,
      6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C, 6'h31, 6'h32, 6'h34, 6'h38,
      6'h1F, 6'h2F, 6'h37, 6'h3B, 6'h3D, 6'h3E};

   logic               dphy_active;
   logic               rst_n_i;
   logic               start_i;
   vc_t                vc_i;
   logic               line_sync_en_i;
   logic               credit_i;
   logic               word_valid_o;
   logic [LANES*8-1:0] word_data_o;
   logic [2:0]         word_nbytes_o;
   logic               busy_o;

   string      test_name = "reset";
   logic       sync_mode = 1'b0;
   logic       stall_mode = 1'b0;
   int         err_count = 0;
   int         checks_run = 0;
   int         tests_run = 0;
   int         tests_failed = 0;
   int         frame_count = 0;
   int         fe_count = 0;
   int         words_rx = 0;
   int         credits_rx = 0;
   int         credits_sent = 0;
   logic [7:0] pkt_q [$];
   seq_state_t ref_kind = FS;
   int         ref_fnum = 1;
   int         ref_line = 1;

   csi2_tx_top #(
      .LANES      (LANES),
      .WORD_COUNT (WORD_COUNT),
      .LINES      (LINES),
      .FNUM_MAX   (FNUM_MAX),
      .CREDITS    (CREDITS)
   ) csi2_tx_top_i (
      .dphy_active    (dphy_active),
      .rst_n_i        (rst_n_i),
      .start_i        (start_i),
      .vc_i           (vc_i),
      .line_sync_en_i (line_sync_en_i),
      .credit_i       (credit_i),
      .word_valid_o   (word_valid_o),
      .word_data_o    (word_data_o),
      .word_nbytes_o  (word_nbytes_o),
      .busy_o         (busy_o)
   );

   initial begin : clock_gen
      dphy_active = 1'b0;
      forever #(PERIOD / 2) dphy_active = ~dphy_active;
   end

   //////////////////////////////
   // reference rules
   //////////////////////////////
   function automatic logic [7:0] header_ecc(input logic [25:0] d);
      logic [5:0] syn;
      syn = '0;
      for (int i = 0; i < 26; i++) begin
         if (d[i]) begin
            syn = syn ^ ECC_COL[i];
         end
      end
      return {d[25], d[24], syn};
   endfunction

   // reflected CRC-16 one byte at a time
   function automatic logic [15:0] crc_update(input logic [15:0] crc, input logic [7:0] b);
      logic [15:0] r;
      r = crc ^ {8'h00, b};
      repeat (8) begin
         r = r[0] ? ((r >> 1) ^ 16'h8408) : (r >> 1);
      end
      return r;
   endfunction

   function automatic dt_t expected_dt(input seq_state_t kind);
      case (kind)
         FS:      return DT_FS;
         LS:      return DT_LS;
         LONG:    return DT_LONG_DEFAULT;
         LE:      return DT_LE;
         default: return DT_FE;
      endcase
   endfunction

   function automatic int packet_length(input seq_state_t kind);
      return (kind == LONG) ? WORD_COUNT + 6 : 4;
   endfunction

   task automatic check_eq(input string check, input int exp_v, input int act_v);
      checks_run++;
      assert (exp_v == act_v) else begin
         $display("[FAIL] %s/%s expected 0x%0h actual 0x%0h", test_name, check, exp_v, act_v);
         err_count++;
      end
   endtask

   task automatic check_packet();
      logic [15:0] crc;
      crc = CRC_SEED;
      check_eq("packet_type", int'(expected_dt(ref_kind)), int'(pkt_q[0][5:0]));
      check_eq("virtual_channel", int'(vc_i[1:0]), int'(pkt_q[0][7:6]));
      check_eq("header_ecc", int'(header_ecc({vc_i[3:2], pkt_q[2], pkt_q[1], pkt_q[0]})),
               int'(pkt_q[3]));
      if (ref_kind == LONG) begin
         check_eq("word_count", WORD_COUNT, int'({pkt_q[2], pkt_q[1]}));
         for (int k = 0; k < WORD_COUNT; k++) begin
            check_eq("payload", (k + ref_line) % 256, int'(pkt_q[4 + k]));
            crc = crc_update(crc, pkt_q[4 + k]);
         end
         check_eq("crc16", int'(crc), int'({pkt_q[WORD_COUNT + 5], pkt_q[WORD_COUNT + 4]}));
      end else if (ref_kind == FS || ref_kind == FE) begin
         check_eq("frame_number", ref_fnum, int'({pkt_q[2], pkt_q[1]}));
      end else begin
         check_eq("line_number", ref_line, int'({pkt_q[2], pkt_q[1]}));
      end
   endtask

   // next packet in frame order
   task automatic advance_model();
      case (ref_kind)
         FS: ref_kind = sync_mode ? LS : LONG;
         LS: ref_kind = LONG;
         LONG: begin
            if (sync_mode) begin
               ref_kind = LE;
            end else if (ref_line == LINES) begin
               ref_kind = FE;
            end else begin
               ref_line++;
            end
         end
         LE: begin
            if (ref_line == LINES) begin
               ref_kind = FE;
            end else begin
               ref_kind = LS;
               ref_line++;
            end
         end
         default: begin
            ref_kind = FS;
            ref_line = 1;
            ref_fnum = (ref_fnum == FNUM_MAX) ? 1 : ref_fnum + 1;
            fe_count++;
         end
      endcase
   endtask

   //////////////////////////////
   // word monitor
   //////////////////////////////
   always @(posedge dphy_active) begin : monitor
      int n;
      if (!rst_n_i) begin
         pkt_q.delete();
         ref_kind = FS;
         ref_line = 1;
         ref_fnum = 1;
      end else if (word_valid_o) begin
         // full word unless the packet ends sooner
         n = packet_length(ref_kind) - pkt_q.size();
         if (n > LANES) begin
            n = LANES;
         end
         check_eq("word_nbytes", n, int'(word_nbytes_o));
         for (int i = 0; i < n; i++) begin
            pkt_q.push_back(word_data_o[i*8 +: 8]);
         end
         if (pkt_q.size() == packet_length(ref_kind)) begin
            check_packet();
            advance_model();
            pkt_q.delete();
         end
      end
   end

   always @(posedge dphy_active) begin : credit_track
      if (!rst_n_i) begin
         words_rx   <= 0;
         credits_rx <= 0;
      end else begin
         if (word_valid_o) begin
            words_rx <= words_rx + 1;
         end
         if (credit_i) begin
            credits_rx <= credits_rx + 1;
         end
      end
   end

   credit_bound: assert property (@(posedge dphy_active) disable iff (!rst_n_i)
      (words_rx - credits_rx) <= CREDITS)
   else begin
      $display("credit limit broken: %0d words outstanding in %s", words_rx - credits_rx,
               test_name);
      err_count++;
   end

   busy_after_fe: assert property (@(posedge dphy_active) disable iff (!rst_n_i)
      $fell(busy_o) |-> (fe_count == frame_count))
   else begin
      $display("busy dropped before the frame end packet was emitted in %s", test_name);
      err_count++;
   end

   // one credit per received word after a random delay
   initial begin : consumer
      int wait_cycles;
      void'($urandom(SEED));
      credit_i = 1'b0;
      forever begin
         @(posedge dphy_active);
         if (rst_n_i && (words_rx > credits_sent)) begin
            wait_cycles = stall_mode ? $urandom_range(STALL_MAX, STALL_MIN)
                                     : $urandom_range(3, 0);
            repeat (wait_cycles) @(posedge dphy_active);
            credit_i <= 1'b1;
            credits_sent++;
            @(posedge dphy_active);
            credit_i <= 1'b0;
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, a frame never completed", WATCHDOG_NS);
      $display("Simulation finished: FAIL");
      $finish;
   end

   //////////////////////////////
   // test sequence
   //////////////////////////////
   task automatic run_frame(input logic sync);
      sync_mode = sync;
      frame_count++;
      @(posedge dphy_active);
      start_i        <= 1'b1;
      line_sync_en_i <= sync;
      @(posedge dphy_active);
      start_i <= 1'b0;
      // busy rises on the next edge and stays high until the frame ends
      do begin
         @(posedge dphy_active);
      end while (busy_o);
   endtask

   task automatic run_test(input string name, input logic sync, input logic stall,
                           input int frames);
      int errs_before;
      errs_before = err_count;
      test_name   = name;
      stall_mode  = stall;
      tests_run++;
      for (int f = 0; f < frames; f++) begin
         run_frame(sync);
      end
      if (err_count != errs_before) begin
         tests_failed++;
      end
      $display("test %s: %0d frames, %0d errors", name, frames, err_count - errs_before);
   endtask

   initial begin : main_seq
      rst_n_i        = 1'b0;
      start_i        = 1'b0;
      vc_i           = 4'hE;
      line_sync_en_i = 1'b0;
      repeat (3) @(posedge dphy_active);
      rst_n_i <= 1'b1;
      @(posedge dphy_active);

      run_test("no_line_sync", 1'b0, 1'b0, 2);
      run_test("line_sync", 1'b1, 1'b0, 2);
      run_test("credit_stall", 1'b1, 1'b1, 2);

      $display("tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d",
               tests_run, tests_failed, checks_run, err_count);
      if (err_count == 0 && tests_failed == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
rtl/csi2_pkg.sv
rtl/csi2_frame_sequencer.sv
rtl/csi2_short_pkt_gen.sv
rtl/csi2_long_pkt_gen.sv
rtl/csi2_lane_arbiter.sv
rtl/csi2_tx_top.sv
tb/csi2_tx_tb.sv

// File: Makefile
# Verilator build and run of the CSI-2 transmitter testbench

VERILATOR ?= verilator
TOP       ?= csi2_tx_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
